/* verilog/thor_decode_pkg.sv */
/*
 * Thor decode definitions shared by the register decode slice.
 * Instruction format, opcode list, special registers, decoded record
 * and the stack-pointer banking helpers.
 */
package thor_decode_pkg;

	// ========================================================================
	// Instruction format
	// ========================================================================

	// Fields are listed from the high bits down to bit 0
	// The opcode occupies bits 6:0 and the function code bits 31:27
	typedef struct packed {
		logic [4:0] func;
		logic [5:0] rb;
		logic [5:0] ra;
		logic [5:0] rt;
		logic [1:0] lk;
		logic [6:0] opcode;
	} instruction_t;

	// Only the opcodes this slice has to tell apart are named here
	// Anything else is treated as an immediate form by the target decoder
	typedef enum logic [6:0] {
		R2   = 7'h02,
		ADD  = 7'h04,
		ADDI = 7'h05,
		MOV  = 7'h0B,
		JMP  = 7'h20,
		DJMP = 7'h21,
		RTS  = 7'h22,
		MTLK = 7'h23,
		JEQ  = 7'h28,
		JNE  = 7'h29,
		JLT  = 7'h2A,
		JGE  = 7'h2B,
		JEQZ = 7'h2C,
		STB  = 7'h70,
		STW  = 7'h71,
		STO  = 7'h73
	} opcode_e;

	// ========================================================================
	// Special register numbers
	// ========================================================================

	localparam logic [5:0] REG_ZERO    = 6'd0;
	localparam logic [5:0] REG_SP      = 6'd31;
	// Loop counter, used implicitly by DJMP
	localparam logic [5:0] REG_LC      = 6'd40;
	// Link register n lives at base plus n, so 41 to 43
	localparam logic [5:0] REG_LK_BASE = 6'd40;
	// Banked stack pointer k lives at base plus k, so 44 to 47
	localparam logic [5:0] REG_SP_BASE = 6'd43;

	// Stack-pointer select, 0 and 5 to 7 leave register 31 alone
	typedef logic [2:0] sp_sel_t;

	// ========================================================================
	// Decoded record and configuration map
	// ========================================================================

	typedef struct packed {
		opcode_e    opcode;
		logic [5:0] rt;
		logic [5:0] ra;
		logic [5:0] rb;
		logic       wr;
	} decode_t;

	// Wishbone word addresses of the configuration block
	localparam logic [3:0]  WB_ADDR_SPSEL = 4'd0;
	localparam logic [3:0]  WB_ADDR_ID    = 4'd1;
	// Identification word returned at WB_ADDR_ID
	localparam logic [31:0] DECODE_ID     = 32'h7D0C_0001;

	// Link selector to register number, a zero selector means no link
	function automatic logic [5:0] link_reg(input logic [1:0] lk);
		if (lk == 2'd0)
			return REG_ZERO;
		return REG_LK_BASE + {4'd0, lk};
	endfunction

	// Swap the generic stack pointer for the bank chosen by sp_sel
	// Every other register number comes back unchanged
	function automatic logic [5:0] remap_sp(input logic [5:0] r, input sp_sel_t sp_sel);
		if (r == REG_SP && sp_sel >= 3'd1 && sp_sel <= 3'd4)
			return REG_SP_BASE + {3'd0, sp_sel};
		return r;
	endfunction

endpackage

/* verilog/thor_decode_rt.sv */
/*
 * Thor target register decoder.
 * Picks the destination register for each opcode class and applies
 * stack-pointer banking, purely combinational.
 */
`timescale 1ns/1ps

module thor_decode_rt
	import thor_decode_pkg::*;
(
	input  instruction_t ir,
	input  sp_sel_t      sp_sel,
	output logic [5:0]   rt
);

	// Target before the stack-pointer remap
	logic [5:0] rt_raw;

	// ========================================================================
	// Target selection by opcode class
	// ========================================================================

	always_comb
	begin
		case (ir.opcode)
			// Conditional jump on zero never writes a register
			JEQZ:
				rt_raw = REG_ZERO;
			// Compare-and-jump and JMP write their link register when lk is set
			JEQ, JNE, JLT, JGE, JMP:
				rt_raw = link_reg(ir.lk);
			// Loop jump decrements the loop counter in place
			DJMP:
				rt_raw = REG_LC;
			// Stores only read registers
			STB, STW, STO:
				rt_raw = REG_ZERO;
			// Return reads a link register, it writes nothing
			RTS:
				rt_raw = REG_ZERO;
			// Move to link uses the same selector encoding as the jumps
			MTLK:
				rt_raw = link_reg(ir.lk);
			// Register forms can reach all 64 registers
			R2, MOV:
				rt_raw = ir.rt;
			// Immediate forms only encode the low 32 registers
			default:
				rt_raw = {1'b0, ir.rt[4:0]};
		endcase
	end

	// ========================================================================
	// Stack-pointer banking
	// ========================================================================

	// A target of 31 lands in the bank for the current mode
	assign rt = remap_sp(rt_raw, sp_sel);

endmodule

/* verilog/thor_decode_rs.sv */
/*
 * Thor source register decoder.
 * Works out both read operands, forcing unused ones to register zero,
 * and applies stack-pointer banking to each.
 */
`timescale 1ns/1ps

module thor_decode_rs
	import thor_decode_pkg::*;
(
	input  instruction_t ir,
	input  sp_sel_t      sp_sel,
	output logic [5:0]   ra,
	output logic [5:0]   rb
);

	// Operands before the stack-pointer remap
	logic [5:0] ra_raw;
	logic [5:0] rb_raw;

	// ========================================================================
	// First source
	// ========================================================================

	always_comb
	begin
		case (ir.opcode)
			// Return jumps through the link register named by lk
			RTS:
				ra_raw = link_reg(ir.lk);
			// Loop jump tests the loop counter
			DJMP:
				ra_raw = REG_LC;
			default:
				ra_raw = ir.ra;
		endcase
	end

	// ========================================================================
	// Second source
	// ========================================================================

	// Only opcodes that actually read rb keep the field
	// Everything else reads register zero so no false dependence is seen
	always_comb
	begin
		case (ir.opcode)
			R2:
				rb_raw = ir.rb;
			JEQ, JNE, JLT, JGE:
				rb_raw = ir.rb;
			// The rb field carries the store data register
			STB, STW, STO:
				rb_raw = ir.rb;
			default:
				rb_raw = REG_ZERO;
		endcase
	end

	// Both operands see the banked stack pointer
	assign ra = remap_sp(ra_raw, sp_sel);
	assign rb = remap_sp(rb_raw, sp_sel);

endmodule

/* verilog/thor_decode_cfg.sv */
/*
 * Thor decode configuration block.
 * Wishbone classic slave holding the stack-pointer select and an ID word.
 */
`timescale 1ns/1ps

module thor_decode_cfg
	import thor_decode_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [3:0]  wb_adr,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic        wb_ack,
	output sp_sel_t     sp_sel
);

	logic        ack_q;
	sp_sel_t     sp_sel_q;
	logic [31:0] rd_data;
	logic [31:0] rd_data_q;
	logic        req;

	// A new request is one not already being acknowledged
	// This makes ack a single-cycle pulse even if the master holds stb
	assign req = wb_cyc & wb_stb & ~ack_q;

	// Read mux, unmapped words read as zero
	always_comb
	begin
		case (wb_adr)
			WB_ADDR_SPSEL: rd_data = {29'd0, sp_sel_q};
			WB_ADDR_ID:    rd_data = DECODE_ID;
			default:       rd_data = 32'd0;
		endcase
	end

	// ========================================================================
	// Control registers
	// ========================================================================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack_q    <= 1'b0;
			sp_sel_q <= '0;
		end
		else
		begin
			ack_q <= req;
			// Only the low three bits of the write data are kept
			if (req && wb_we && wb_adr == WB_ADDR_SPSEL)
				sp_sel_q <= wb_dat_i[2:0];
		end
	end

	// Read data is captured with the request and shown during the ack
	always_ff @(posedge clk)
	begin
		if (req)
			rd_data_q <= rd_data;
	end

	assign wb_ack   = ack_q;
	assign wb_dat_o = rd_data_q;
	assign sp_sel   = sp_sel_q;

endmodule

/* verilog/thor_decode_stage.sv */
/*
 * Thor register decode pipeline stage.
 * Runs the target and source decoders on the incoming instruction and
 * holds the decoded record in a one-entry valid/ready register.
 */
`timescale 1ns/1ps

module thor_decode_stage
	import thor_decode_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  sp_sel_t      sp_sel,
	input  logic         in_valid,
	input  instruction_t in_insn,
	output logic         in_ready,
	output logic         out_valid,
	input  logic         out_ready,
	output decode_t      out_dec
);

	// Decoder results for the instruction currently offered
	logic [5:0] rt_d;
	logic [5:0] ra_d;
	logic [5:0] rb_d;
	decode_t    dec_d;

	// Output register state
	logic       out_valid_q;
	decode_t    dec_q;
	logic       accept;

	// ========================================================================
	// Combinational decode
	// ========================================================================

	thor_decode_rt i_thor_decode_rt (
		.ir     (in_insn),
		.sp_sel (sp_sel),
		.rt     (rt_d)
	);

	thor_decode_rs i_thor_decode_rs (
		.ir     (in_insn),
		.sp_sel (sp_sel),
		.ra     (ra_d),
		.rb     (rb_d)
	);

	// Assemble the record, a write is flagged whenever the target is real
	always_comb
	begin
		dec_d.opcode = opcode_e'(in_insn.opcode);
		dec_d.rt     = rt_d;
		dec_d.ra     = ra_d;
		dec_d.rb     = rb_d;
		dec_d.wr     = (rt_d != REG_ZERO);
	end

	// ========================================================================
	// Valid/ready register
	// ========================================================================

	// The slot is free when empty or when its record leaves this cycle
	assign in_ready = out_ready | ~out_valid_q;
	assign accept   = in_valid & in_ready;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_valid_q <= 1'b0;
		else if (in_ready)
			out_valid_q <= in_valid;
	end

	// Record holds its value under back-pressure since accept is low then
	always_ff @(posedge clk)
	begin
		if (accept)
			dec_q <= dec_d;
	end

	assign out_valid = out_valid_q;
	assign out_dec   = dec_q;

endmodule

/* verilog/thor_decode_top.sv */
/*
 * Thor register decode slice top level.
 * Configuration block beside the decode stage it steers.
 */
`timescale 1ns/1ps

module thor_decode_top
	import thor_decode_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         wb_cyc,
	input  logic         wb_stb,
	input  logic         wb_we,
	input  logic [3:0]   wb_adr,
	input  logic [31:0]  wb_dat_i,
	output logic [31:0]  wb_dat_o,
	output logic         wb_ack,
	input  logic         in_valid,
	input  instruction_t in_insn,
	output logic         in_ready,
	output logic         out_valid,
	input  logic         out_ready,
	output decode_t      out_dec
);

	// Current stack-pointer bank, written over Wishbone
	sp_sel_t sp_sel;

	thor_decode_cfg i_thor_decode_cfg (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack   (wb_ack),
		.sp_sel   (sp_sel)
	);

	thor_decode_stage i_thor_decode_stage (
		.clk       (clk),
		.rst_n     (rst_n),
		.sp_sel    (sp_sel),
		.in_valid  (in_valid),
		.in_insn   (in_insn),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_dec   (out_dec)
	);

endmodule

/* verif/thor_decode_asserts.sv */
/*
 * Concurrent checks on the decode stream and Wishbone handshakes,
 * bound into the top level where both ports meet.
 */
`timescale 1ns/1ps

module thor_decode_asserts
	import thor_decode_pkg::*;
(
	input logic    clk,
	input logic    rst_n,
	input logic    out_valid,
	input logic    out_ready,
	input decode_t out_dec,
	input logic    wb_cyc,
	input logic    wb_stb,
	input logic    wb_ack
);

	// A stalled record must not change until the consumer takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> $stable(out_dec))
		else $error("out_dec changed while out_valid was high and out_ready low");

	// The synchronous reset empties the output slot
	assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid was high after reset");

	// Ack is a single-cycle pulse
	assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for more than one cycle");

	// Every ack answers a request seen on the previous edge
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack without a preceding cyc and stb");

endmodule

// Stream and bus both surface on the top level ports
bind thor_decode_top thor_decode_asserts i_thor_decode_asserts (
	.clk(clk), .rst_n(rst_n),
	.out_valid(out_valid), .out_ready(out_ready), .out_dec(out_dec),
	.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack)
);

/* verif/thor_decode_tb.sv */
/*
 * Directed testbench for the Thor register decode slice.
 * Drives the Wishbone and instruction stream ports, models the decode
 * rules and checks every record that leaves the stage.
 */
`timescale 1ns/1ps

module thor_decode_tb
	import thor_decode_pkg::*;
;

	// Cycles each test is expected to need, summed for the watchdog
	localparam int CYCLE_BUDGET = 5 + 20 + 50 + 25 + 80 + 200;
	localparam int CYCLE_LIMIT  = CYCLE_BUDGET * 3 / 2;

	logic         clk;
	logic         rst_n;
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic [3:0]   wb_adr;
	logic [31:0]  wb_dat_i;
	logic [31:0]  wb_dat_o;
	logic         wb_ack;
	logic         in_valid;
	instruction_t in_insn;
	logic         in_ready;
	logic         out_valid;
	logic         out_ready;
	decode_t      out_dec;

	// Records accepted by the DUT that have not yet left it
	decode_t      expected_q[$];
	sp_sel_t      sp_model;
	logic [15:0]  lfsr;
	int           errors;
	int           checks;
	int           received;
	int           cycles;

	// Every opcode the slice names, indexed by four random bits
	opcode_e op_table [16] = '{ADD, ADDI, R2, MOV, JEQ, JNE, JLT, JGE,
		JEQZ, JMP, DJMP, RTS, MTLK, STB, STW, STO};

	thor_decode_top i_thor_decode_top (.*);

	always #50 clk = ~clk;

	// Watchdog on the total run length
	always @(posedge clk)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ========================================================================
	// Random source and reference model
	// ========================================================================

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// One LFSR step for every bit handed out
	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic rand_insn(output instruction_t insn);
		logic [31:0] r;
		rand_bits(32, r);
		insn = r;
		rand_bits(4, r);
		insn.opcode = op_table[r[3:0]];
	endtask

	function automatic instruction_t make_insn(input opcode_e op, input logic [1:0] lk,
			input logic [5:0] rt, input logic [5:0] ra, input logic [5:0] rb);
		instruction_t i;
		i = '0;
		i.opcode = op;
		i.lk = lk;
		i.rt = rt;
		i.ra = ra;
		i.rb = rb;
		return i;
	endfunction

	// Register 31 moves to bank 44 to 47 for selects 1 to 4 only
	function automatic logic [5:0] bank(input logic [5:0] r, input sp_sel_t s);
		if (r != 6'd31)
			return r;
		case (s)
			3'd1: return 6'd44;
			3'd2: return 6'd45;
			3'd3: return 6'd46;
			3'd4: return 6'd47;
			default: return r;
		endcase
	endfunction

	function automatic decode_t model_decode(input instruction_t i, input sp_sel_t s);
		decode_t d;
		logic [5:0] lnk;
		lnk = (i.lk == 2'd0) ? REG_ZERO : REG_LK_BASE + 6'(i.lk);
		d.opcode = opcode_e'(i.opcode);
		case (i.opcode)
			JEQZ, STB, STW, STO, RTS: d.rt = REG_ZERO;
			JEQ, JNE, JLT, JGE, JMP, MTLK: d.rt = lnk;
			DJMP: d.rt = REG_LC;
			R2, MOV: d.rt = i.rt;
			default: d.rt = {1'b0, i.rt[4:0]};
		endcase
		case (i.opcode)
			RTS: d.ra = lnk;
			DJMP: d.ra = REG_LC;
			default: d.ra = i.ra;
		endcase
		case (i.opcode)
			R2, JEQ, JNE, JLT, JGE, STB, STW, STO: d.rb = i.rb;
			default: d.rb = REG_ZERO;
		endcase
		d.rt = bank(d.rt, s);
		d.ra = bank(d.ra, s);
		d.rb = bank(d.rb, s);
		d.wr = (d.rt != REG_ZERO);
		return d;
	endfunction

	// ========================================================================
	// Compare tasks
	// ========================================================================

	// Field by field view of a decoded record
	function automatic string dec_str(input decode_t d);
		return $sformatf("op=%h rt=%0d ra=%0d rb=%0d wr=%b", d.opcode, d.rt, d.ra, d.rb, d.wr);
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_dec(input string name, input decode_t exp, input decode_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %s got %s", $time, name,
				dec_str(exp), dec_str(act));
		end
	endtask

	// ========================================================================
	// Bus and stream drivers
	// ========================================================================

	task automatic wb_access(input logic we, input logic [3:0] adr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = wdata;
		@(negedge clk);
		while (!wb_ack && waited < 8)
		begin
			@(negedge clk);
			waited++;
		end
		if (!wb_ack)
		begin
			errors++;
			$display("Wishbone access to address %0d was never acknowledged", adr);
		end
		rdata = wb_dat_o;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (we && adr == WB_ADDR_SPSEL)
			sp_model = wdata[2:0];
	endtask

	// One clock of the stream, driven at the falling edge
	// Handshakes are judged here and take effect at the next rising edge
	task automatic stream_cycle(input logic v, input instruction_t insn, input logic rdy,
			output logic taken);
		decode_t exp;
		logic    ready_exp;
		@(negedge clk);
		in_valid = v;
		in_insn = insn;
		out_ready = rdy;
		#1;
		// The slot is free when the model holds nothing or its record leaves now
		ready_exp = rdy | (expected_q.size() == 0);
		check_bit("out_valid", expected_q.size() != 0, out_valid);
		check_bit("in_ready", ready_exp, in_ready);
		taken = v & ready_exp;
		// Transfers seen on the DUT port, counted apart from the model
		if (out_valid && rdy)
			received++;
		if (rdy && expected_q.size() != 0)
		begin
			exp = expected_q.pop_front();
			check_dec("out_dec", exp, out_dec);
		end
		if (taken)
			expected_q.push_back(model_decode(insn, sp_model));
	endtask

	task automatic drain_outputs();
		logic taken;
		int n;
		n = 0;
		while (expected_q.size() != 0 && n < 10)
		begin
			stream_cycle(1'b0, '0, 1'b1, taken);
			n++;
		end
		if (expected_q.size() != 0)
		begin
			errors++;
			$display("Decoded records never left the stage, %0d outstanding", expected_q.size());
			expected_q.delete();
		end
	endtask

	task automatic send_insn(input instruction_t insn);
		logic taken;
		int n;
		n = 0;
		taken = 1'b0;
		while (!taken && n < 10)
		begin
			stream_cycle(1'b1, insn, 1'b1, taken);
			n++;
		end
		if (!taken)
		begin
			errors++;
			$display("Instruction %h was never accepted", insn);
		end
		drain_outputs();
	endtask

	task automatic end_test(input string name, input int start);
		$display("%s: %s with %0d errors", name, (errors == start) ? "passed" : "failed",
			errors - start);
	endtask

	// ========================================================================
	// Directed tests
	// ========================================================================

	task automatic test_reset_id();
		int start;
		logic [31:0] rd;
		start = errors;
		@(negedge clk);
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("in_ready", 1'b1, in_ready);
		check_bit("wb_ack", 1'b0, wb_ack);
		wb_access(1'b0, WB_ADDR_SPSEL, 32'd0, rd);
		check_word("wb_dat_o spsel", 32'd0, rd);
		wb_access(1'b0, WB_ADDR_ID, 32'd0, rd);
		check_word("wb_dat_o id", DECODE_ID, rd);
		wb_access(1'b0, 4'd9, 32'd0, rd);
		check_word("wb_dat_o unmapped", 32'd0, rd);
		end_test("reset and id", start);
	endtask

	task automatic test_target();
		int start;
		start = errors;
		send_insn(make_insn(ADD, 2'd0, 6'd5, 6'd1, 6'd2));
		// Immediate form with rt 45 keeps only the low five bits
		send_insn(make_insn(ADDI, 2'd0, 6'd45, 6'd3, 6'd4));
		send_insn(make_insn(R2, 2'd0, 6'd50, 6'd6, 6'd7));
		send_insn(make_insn(MOV, 2'd0, 6'd33, 6'd8, 6'd9));
		// Link targets 41 to 43 and the no-link case
		send_insn(make_insn(JEQ, 2'd1, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(JNE, 2'd2, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(JLT, 2'd3, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(JGE, 2'd0, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(JMP, 2'd2, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(MTLK, 2'd3, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(JEQZ, 2'd1, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(DJMP, 2'd1, 6'd12, 6'd1, 6'd2));
		send_insn(make_insn(RTS, 2'd1, 6'd12, 6'd1, 6'd2));
		// Stores carry a register in rt but must not flag a write
		send_insn(make_insn(STB, 2'd0, 6'd20, 6'd1, 6'd2));
		send_insn(make_insn(STW, 2'd0, 6'd21, 6'd1, 6'd2));
		send_insn(make_insn(STO, 2'd0, 6'd22, 6'd1, 6'd2));
		end_test("target decode", start);
	endtask

	task automatic test_source();
		int start;
		start = errors;
		for (int lk = 0; lk < 4; lk++)
			send_insn(make_insn(RTS, 2'(lk), 6'd0, 6'd17, 6'd18));
		send_insn(make_insn(DJMP, 2'd0, 6'd0, 6'd17, 6'd18));
		send_insn(make_insn(R2, 2'd0, 6'd1, 6'd7, 6'd9));
		send_insn(make_insn(STW, 2'd0, 6'd0, 6'd12, 6'd60));
		// An ALU form reads no second operand
		send_insn(make_insn(ADD, 2'd0, 6'd1, 6'd12, 6'd20));
		end_test("source decode", start);
	endtask

	task automatic test_banking();
		int start;
		logic [31:0] rd;
		start = errors;
		for (int v = 0; v < 8; v++)
		begin
			// Upper write bits are junk and must be dropped
			wb_access(1'b1, WB_ADDR_SPSEL, 32'hFFFF_FFF8 | 32'(v), rd);
			wb_access(1'b0, WB_ADDR_SPSEL, 32'd0, rd);
			check_word("wb_dat_o spsel", 32'(v), rd);
			send_insn(make_insn(R2, 2'd0, REG_SP, REG_SP, REG_SP));
			send_insn(make_insn(STO, 2'd0, 6'd0, REG_SP, REG_SP));
		end
		end_test("stack-pointer banking", start);
	endtask

	task automatic test_streaming();
		int start;
		int start_rx;
		int sent;
		logic [31:0] r;
		logic taken;
		instruction_t cur;
		start = errors;
		start_rx = received;
		sent = 0;
		wb_access(1'b1, WB_ADDR_SPSEL, 32'd3, r);
		rand_insn(cur);
		// An offered instruction is held until the stage takes it
		while (sent < 40)
		begin
			rand_bits(3, r);
			stream_cycle(r[2], cur, r[1] | r[0], taken);
			if (taken)
			begin
				sent++;
				rand_insn(cur);
			end
		end
		drain_outputs();
		check_word("records received", 32'd40, 32'(received - start_rx));
		end_test("back-pressure stream", start);
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		in_valid = 1'b0;
		in_insn = '0;
		out_ready = 1'b0;
		sp_model = '0;
		lfsr = 16'd84;
		errors = 0;
		checks = 0;
		received = 0;
		cycles = 0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		test_reset_id();
		test_target();
		test_source();
		test_banking();
		test_streaming();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* filelist.f */
verilog/thor_decode_pkg.sv
verilog/thor_decode_rt.sv
verilog/thor_decode_rs.sv
verilog/thor_decode_cfg.sv
verilog/thor_decode_stage.sv
verilog/thor_decode_top.sv
verif/thor_decode_asserts.sv
verif/thor_decode_tb.sv

/* Makefile */
# Verilator lint and simulation of the Thor register decode slice

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module thor_decode_tb -f filelist.f

# The run passes only when the testbench prints its pass message
sim:
	verilator --binary --timing --assert --top-module thor_decode_tb -Mdir obj_dir -f filelist.f
	@out=$$(./obj_dir/Vthor_decode_tb 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir
